//--- tb.f
soc_ctrl_pkg.sv
apb_if.sv
apb_decode.sv
cfg_regs.sv
clint.sv
irq_ctrl.sv
soc_ctrl.sv
tb_soc_ctrl.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_soc_ctrl
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) *.sv
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# exit status of the simulation is the result
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_soc_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_ctrl;
    import soc_ctrl_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int MAX_ENTRIES  = 96;
    // strobe patterns used by the random writes, one nibble each
    localparam logic [19:0] STRB_MIX = 20'hc_1_a_5_f;

    typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_SRC, OP_IDLE} tb_op_e;

    typedef struct packed {
        tb_op_e            op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic [DATA_W-1:0] exp;
        logic              err;
        logic              live;
        logic [3:0]        pins;
        logic [DATA_W-1:0] bootvec;
        logic [DATA_W-1:0] ddr;
    } entry_t;

    logic              clk;
    logic              arst_n;
    logic              psel;
    logic              penable;
    logic [ADDR_W-1:0] paddr;
    logic              pwrite;
    logic [STRB_W-1:0] pstrb;
    logic [DATA_W-1:0] pwdata;
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;
    logic              uart_irq;
    logic              spi_irq;
    logic [DATA_W-1:0] core_bootvec;
    logic [DATA_W-1:0] ddr_offset;
    logic              core_rstn;
    logic              msip;
    logic              mtip;
    logic              meip;

    entry_t            vectors [MAX_ENTRIES];
    int                n_entries;
    int                cur_entry;
    int                error_count;
    int                cycles;
    logic [31:0]       rng;
    logic [63:0]       mtime_m;
    logic [63:0]       mtime_snap;

    // expected state while the table is built
    logic [DATA_W-1:0] m_boot;
    logic [DATA_W-1:0] m_ddr;
    logic              m_rstn;
    logic              m_msip;
    logic              m_mtip;
    logic              m_meip;

    soc_ctrl u_soc_ctrl (
        .clk          ( clk          ),
        .arst_n       ( arst_n       ),
        .psel         ( psel         ),
        .penable      ( penable      ),
        .paddr        ( paddr        ),
        .pwrite       ( pwrite       ),
        .pstrb        ( pstrb        ),
        .pwdata       ( pwdata       ),
        .prdata       ( prdata       ),
        .pready       ( pready       ),
        .pslverr      ( pslverr      ),
        .uart_irq     ( uart_irq     ),
        .spi_irq      ( spi_irq      ),
        .core_bootvec ( core_bootvec ),
        .ddr_offset   ( ddr_offset   ),
        .core_rstn    ( core_rstn    ),
        .msip         ( msip         ),
        .mtip         ( mtip         ),
        .meip         ( meip         )
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // reference time, one tick per clock once reset is released
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mtime_m <= '0;
        end else begin
            mtime_m <= mtime_m + 64'd1;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                                input logic [31:0] new_val,
                                                input logic [3:0]  strb);
        logic [31:0] mask;
        for (int b = 0; b < 4; b++) begin
            mask[8*b +: 8] = {8{strb[b]}};
        end
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    function automatic logic [ADDR_W-1:0] addr_of(input apb_slave_e slv,
                                                  input logic [SLV_SEL_LSB-1:0] ofs);
        logic [ADDR_W-1:0] a;
        a = '0;
        a[SLV_SEL_LSB +: 2]    = slv;
        a[SLV_SEL_LSB-1:0]     = ofs;
        return a;
    endfunction

    task automatic check_value(input string name, input logic [63:0] act,
                               input logic [63:0] exp);
        if (act !== exp) begin
            error_count++;
            $display("ERROR: entry %0d %s = 0x%0h, expected 0x%0h",
                     cur_entry, name, act, exp);
            $display("Some tests failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic add_entry(input tb_op_e op, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb,
                             input logic [DATA_W-1:0] exp, input logic err,
                             input logic live);
        vectors[n_entries] = '{op, addr, data, strb, exp, err, live,
                               {m_rstn, m_msip, m_mtip, m_meip}, m_boot, m_ddr};
        n_entries++;
    endtask

    task automatic build_table();
        logic [DATA_W-1:0] d;
        logic [STRB_W-1:0] s;
        m_boot = RESET_BOOTVEC;
        m_ddr  = RESET_DDR_OFFSET;
        m_rstn = 1'b0;
        m_msip = 1'b0;
        m_mtip = 1'b0;
        m_meip = 1'b0;

        // reset values
        add_entry(OP_IDLE, '0, '0, '0, '0, 1'b0, 1'b0);
        add_entry(OP_READ, addr_of(SLV_CFG, CFG_BOOTVEC_OFS), '0, '0, RESET_BOOTVEC, 0, 0);
        add_entry(OP_READ, addr_of(SLV_CFG, CFG_DDR_OFFSET_OFS), '0, '0, RESET_DDR_OFFSET, 0, 0);
        add_entry(OP_READ, addr_of(SLV_CFG, CFG_CORE_RST_OFS), '0, '0, 32'h0, 0, 0);

        // random data, mixed byte strobes
        for (int k = 0; k < 5; k++) begin
            s      = STRB_MIX[4*k +: 4];
            rng    = xorshift32(rng);
            d      = rng;
            m_boot = merge_bytes(m_boot, d, s);
            add_entry(OP_WRITE, addr_of(SLV_CFG, CFG_BOOTVEC_OFS), d, s, '0, 0, 0);
            add_entry(OP_READ, addr_of(SLV_CFG, CFG_BOOTVEC_OFS), '0, '0, m_boot, 0, 0);
            rng    = xorshift32(rng);
            d      = rng;
            m_ddr  = merge_bytes(m_ddr, d, s);
            add_entry(OP_WRITE, addr_of(SLV_CFG, CFG_DDR_OFFSET_OFS), d, s, '0, 0, 0);
            add_entry(OP_READ, addr_of(SLV_CFG, CFG_DDR_OFFSET_OFS), '0, '0, m_ddr, 0, 0);
        end
        m_rstn = 1'b1;
        add_entry(OP_WRITE, addr_of(SLV_CFG, CFG_CORE_RST_OFS), 32'h1, 4'hf, '0, 0, 0);
        add_entry(OP_READ, addr_of(SLV_CFG, CFG_CORE_RST_OFS), '0, '0, 32'h1, 0, 0);

        // unknown cfg offset leaves the registers alone
        rng = xorshift32(rng);
        add_entry(OP_WRITE, addr_of(SLV_CFG, 12'h00c), rng, 4'hf, '0, 1, 0);
        add_entry(OP_READ, addr_of(SLV_CFG, 12'h00c), '0, '0, 32'h0, 1, 0);
        add_entry(OP_READ, addr_of(SLV_CFG, CFG_BOOTVEC_OFS), '0, '0, m_boot, 0, 0);

        // software interrupt and timer compare
        m_msip = 1'b1;
        add_entry(OP_WRITE, addr_of(SLV_CLINT, CLINT_MSIP_OFS), 32'h1, 4'hf, '0, 0, 0);
        add_entry(OP_READ, addr_of(SLV_CLINT, CLINT_MSIP_OFS), '0, '0, 32'h1, 0, 0);
        add_entry(OP_WRITE, addr_of(SLV_CLINT, CLINT_MTIMECMP_LO_OFS), 32'h0, 4'hf, '0, 0, 0);
        m_mtip = 1'b1;
        add_entry(OP_WRITE, addr_of(SLV_CLINT, CLINT_MTIMECMP_HI_OFS), 32'h0, 4'hf, '0, 0, 0);
        add_entry(OP_READ, addr_of(SLV_CLINT, CLINT_MTIMECMP_LO_OFS), '0, '0, 32'h0, 0, 0);
        m_mtip = 1'b0;
        add_entry(OP_WRITE, addr_of(SLV_CLINT, CLINT_MTIMECMP_LO_OFS), '1, 4'hf, '0, 0, 0);
        add_entry(OP_WRITE, addr_of(SLV_CLINT, CLINT_MTIMECMP_HI_OFS), '1, 4'hf, '0, 0, 0);
        add_entry(OP_READ, addr_of(SLV_CLINT, CLINT_MTIMECMP_HI_OFS), '0, '0, '1, 0, 0);

        // mtime runs on its own and rejects writes
        add_entry(OP_READ, addr_of(SLV_CLINT, CLINT_MTIME_LO_OFS), '0, '0, '0, 0, 1);
        add_entry(OP_READ, addr_of(SLV_CLINT, CLINT_MTIME_LO_OFS), '0, '0, '0, 0, 1);
        add_entry(OP_WRITE, addr_of(SLV_CLINT, CLINT_MTIME_LO_OFS), 32'h0, 4'hf, '0, 1, 0);
        add_entry(OP_READ, addr_of(SLV_CLINT, CLINT_MTIME_LO_OFS), '0, '0, '0, 0, 1);
        add_entry(OP_WRITE, addr_of(SLV_CLINT, CLINT_MTIME_HI_OFS), '1, 4'hf, '0, 1, 0);
        add_entry(OP_READ, addr_of(SLV_CLINT, CLINT_MTIME_HI_OFS), '0, '0, '0, 0, 1);

        // unmapped slave select
        add_entry(OP_WRITE, addr_of(SLV_NONE, 12'h000), 32'h1, 4'hf, '0, 1, 0);
        add_entry(OP_READ, addr_of(SLV_NONE, 12'h000), '0, '0, 32'h0, 1, 0);

        // external interrupts
        add_entry(OP_WRITE, addr_of(SLV_IRQ, IRQ_ENABLE_OFS), 32'h6, 4'hf, '0, 0, 0);
        add_entry(OP_READ, addr_of(SLV_IRQ, IRQ_ENABLE_OFS), '0, '0, 32'h6, 0, 0);
        m_meip = 1'b1;
        add_entry(OP_SRC, '0, 32'h2, '0, '0, 0, 0);
        add_entry(OP_IDLE, '0, '0, '0, '0, 0, 0);
        add_entry(OP_READ, addr_of(SLV_IRQ, IRQ_PENDING_OFS), '0, '0, 32'h2, 0, 0);
        add_entry(OP_SRC, '0, 32'h0, '0, '0, 0, 0);
        add_entry(OP_READ, addr_of(SLV_IRQ, IRQ_PENDING_OFS), '0, '0, 32'h2, 0, 0);
        m_meip = 1'b0;
        add_entry(OP_WRITE, addr_of(SLV_IRQ, IRQ_PENDING_OFS), 32'h2, 4'hf, '0, 0, 0);
        add_entry(OP_READ, addr_of(SLV_IRQ, IRQ_PENDING_OFS), '0, '0, 32'h0, 0, 0);
        add_entry(OP_WRITE, addr_of(SLV_IRQ, IRQ_ENABLE_OFS), 32'h0, 4'hf, '0, 0, 0);
        add_entry(OP_SRC, '0, 32'h4, '0, '0, 0, 0);
        add_entry(OP_IDLE, '0, '0, '0, '0, 0, 0);
        add_entry(OP_READ, addr_of(SLV_IRQ, IRQ_PENDING_OFS), '0, '0, 32'h4, 0, 0);
        add_entry(OP_SRC, '0, 32'h0, '0, '0, 0, 0);
        add_entry(OP_WRITE, addr_of(SLV_IRQ, IRQ_PENDING_OFS), 32'h4, 4'hf, '0, 0, 0);
        add_entry(OP_READ, addr_of(SLV_IRQ, IRQ_PENDING_OFS), '0, '0, 32'h0, 0, 0);
        add_entry(OP_READ, addr_of(SLV_IRQ, 12'h008), '0, '0, 32'h0, 1, 0);
    endtask

    // starts 2 ns after a rising edge, ends 2 ns after the edge that closes the access
    task automatic apb_transfer(input entry_t e);
        logic [DATA_W-1:0] rdata;
        logic              rerr;
        logic              rrdy;
        logic [DATA_W-1:0] exp_rd;
        psel    = 1'b1;
        penable = 1'b0;
        paddr   = e.addr;
        pwrite  = (e.op == OP_WRITE);
        pstrb   = (e.op == OP_WRITE) ? e.strb : '0;
        pwdata  = (e.op == OP_WRITE) ? e.data : '0;
        @(posedge clk);
        #2 penable = 1'b1;
        @(negedge clk);
        rdata      = prdata;
        rerr       = pslverr;
        rrdy       = pready;
        mtime_snap = mtime_m;
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        check_value("pready", {63'd0, rrdy}, 64'd1);
        check_value("pslverr", {63'd0, rerr}, {63'd0, e.err});
        if (e.op == OP_READ) begin
            exp_rd = e.exp;
            if (e.live) begin
                exp_rd = (e.addr[SLV_SEL_LSB-1:0] == CLINT_MTIME_HI_OFS) ?
                         mtime_snap[63:32] : mtime_snap[31:0];
            end
            check_value("prdata", {32'd0, rdata}, {32'd0, exp_rd});
        end
    endtask

    task automatic apply_entry(input entry_t e);
        case (e.op)
            OP_WRITE, OP_READ: apb_transfer(e);
            OP_SRC: begin
                uart_irq = e.data[1];
                spi_irq  = e.data[2];
                @(posedge clk);
                #2;
            end
            default: begin
                @(posedge clk);
                #2;
            end
        endcase
        check_value("core_rstn", {63'd0, core_rstn}, {63'd0, e.pins[3]});
        check_value("msip", {63'd0, msip}, {63'd0, e.pins[2]});
        check_value("mtip", {63'd0, mtip}, {63'd0, e.pins[1]});
        check_value("meip", {63'd0, meip}, {63'd0, e.pins[0]});
        check_value("core_bootvec", {32'd0, core_bootvec}, {32'd0, e.bootvec});
        check_value("ddr_offset", {32'd0, ddr_offset}, {32'd0, e.ddr});
    endtask

    // watchdog sized from the table length
    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= 4 * n_entries + RESET_CYCLES) begin
                $display("Some tests failed");
                $fatal(1, "run timed out after %0d cycles", cycles);
            end
        end
    end

    initial begin
        arst_n      = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        paddr       = '0;
        pwrite      = 1'b0;
        pstrb       = '0;
        pwdata      = '0;
        uart_irq    = 1'b0;
        spi_irq     = 1'b0;
        n_entries   = 0;
        cur_entry   = 0;
        error_count = 0;
        rng         = 32'h5172;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #2 arst_n = 1'b1;
        for (int i = 0; i < n_entries; i++) begin
            cur_entry = i;
            apply_entry(vectors[i]);
        end
        if (error_count == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Some tests failed");
            $fatal(1, "%0d checks did not match", error_count);
        end
    end

endmodule

`default_nettype wire

//--- soc_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module soc_ctrl (
    input  logic                            clk,
    input  logic                            arst_n,

    // apb slave port from the memory arbiter
    input  logic                            psel,
    input  logic                            penable,
    input  logic [soc_ctrl_pkg::ADDR_W-1:0] paddr,
    input  logic                            pwrite,
    input  logic [soc_ctrl_pkg::STRB_W-1:0] pstrb,
    input  logic [soc_ctrl_pkg::DATA_W-1:0] pwdata,
    output logic [soc_ctrl_pkg::DATA_W-1:0] prdata,
    output logic                            pready,
    output logic                            pslverr,

    // peripheral request lines
    input  logic                            uart_irq,
    input  logic                            spi_irq,

    // towards the core
    output logic [soc_ctrl_pkg::DATA_W-1:0] core_bootvec,
    output logic [soc_ctrl_pkg::DATA_W-1:0] ddr_offset,
    output logic                            core_rstn,
    output logic                            msip,
    output logic                            mtip,
    output logic                            meip
);
    import soc_ctrl_pkg::*;

    logic [NUM_IRQ-1:0] srcs;

    apb_if cfg_apb     (.clk(clk));
    apb_if cfg_apb_s   (.clk(clk));
    apb_if clint_apb_s (.clk(clk));
    apb_if irq_apb_s   (.clk(clk));

    assign cfg_apb.psel    = psel;
    assign cfg_apb.penable = penable;
    assign cfg_apb.paddr   = paddr;
    assign cfg_apb.pwrite  = pwrite;
    assign cfg_apb.pstrb   = pstrb;
    assign cfg_apb.pwdata  = pwdata;
    assign prdata          = cfg_apb.prdata;
    assign pready          = cfg_apb.pready;
    assign pslverr         = cfg_apb.pslverr;

    // reserved source in bit 0
    assign srcs = {spi_irq, uart_irq, 1'b0};

    apb_decode u_apb_decode (
        .s     ( cfg_apb.slave      ),
        .cfg   ( cfg_apb_s.master   ),
        .clint ( clint_apb_s.master ),
        .irq   ( irq_apb_s.master   )
    );

    cfg_regs u_cfg_regs (
        .clk          ( clk             ),
        .arst_n       ( arst_n          ),
        .apb          ( cfg_apb_s.slave ),
        .core_bootvec ( core_bootvec    ),
        .ddr_offset   ( ddr_offset      ),
        .core_rstn    ( core_rstn       )
    );

    clint u_clint (
        .clk    ( clk               ),
        .arst_n ( arst_n            ),
        .apb    ( clint_apb_s.slave ),
        .msip   ( msip              ),
        .mtip   ( mtip              )
    );

    irq_ctrl u_irq_ctrl (
        .clk    ( clk             ),
        .arst_n ( arst_n          ),
        .apb    ( irq_apb_s.slave ),
        .srcs   ( srcs            ),
        .meip   ( meip            )
    );

endmodule

`default_nettype wire

//--- irq_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl (
    input  logic                             clk,
    input  logic                             arst_n,
    apb_if.slave                             apb,
    input  logic [soc_ctrl_pkg::NUM_IRQ-1:0] srcs,
    output logic                             meip
);
    import soc_ctrl_pkg::*;

    logic [NUM_IRQ-1:0]     pending_q;
    logic [NUM_IRQ-1:0]     enable_q;
    logic [NUM_IRQ-1:0]     src_set;
    logic [NUM_IRQ-1:0]     clr;
    logic [SLV_SEL_LSB-1:0] ofs;
    logic                   access;
    logic                   wr_en;
    logic                   ofs_hit;

    assign ofs    = apb.paddr[SLV_SEL_LSB-1:0];
    assign access = apb.psel && apb.penable;
    assign wr_en  = access && apb.pwrite;

    // bit 0 is reserved and masked off
    assign src_set = srcs & ~{{(NUM_IRQ-1){1'b0}}, 1'b1};

    // write one to clear, low byte lane only
    assign clr = (wr_en && (ofs == IRQ_PENDING_OFS) && apb.pstrb[0]) ?
                 apb.pwdata[NUM_IRQ-1:0] : '0;

    always_comb begin
        ofs_hit = 1'b1;
        case (ofs)
            IRQ_PENDING_OFS: apb.prdata = {{(DATA_W-NUM_IRQ){1'b0}}, pending_q};
            IRQ_ENABLE_OFS:  apb.prdata = {{(DATA_W-NUM_IRQ){1'b0}}, enable_q};
            default: begin
                apb.prdata = '0;
                ofs_hit    = 1'b0;
            end
        endcase
    end

    assign apb.pready  = 1'b1;
    assign apb.pslverr = access && !ofs_hit;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending_q <= '0;
            enable_q  <= '0;
        end else begin
            // a source still high wins over the clear
            pending_q <= (pending_q & ~clr) | src_set;
            if (wr_en && (ofs == IRQ_ENABLE_OFS) && apb.pstrb[0]) begin
                enable_q <= apb.pwdata[NUM_IRQ-1:0];
            end
        end
    end

    assign meip = |(pending_q & enable_q);

    // meip only rises after an enabled source fired or the mask was written
    a_meip_has_cause: assert property (
        @(posedge clk) disable iff (!arst_n)
        $rose(meip) |-> $past(|(src_set & enable_q)) ||
                        $past(wr_en && (ofs == IRQ_ENABLE_OFS))
    );

endmodule

`default_nettype wire

//--- clint.sv
`timescale 1ns/1ps
`default_nettype none

module clint (
    input  logic clk,
    input  logic arst_n,
    apb_if.slave apb,
    output logic msip,
    output logic mtip
);
    import soc_ctrl_pkg::*;

    logic [2*DATA_W-1:0]    mtime_q;
    logic [2*DATA_W-1:0]    mtimecmp_q;
    logic [SLV_SEL_LSB-1:0] ofs;
    logic                   access;
    logic                   wr_en;
    logic                   ofs_hit;
    logic                   mtime_ofs;

    assign ofs       = apb.paddr[SLV_SEL_LSB-1:0];
    assign access    = apb.psel && apb.penable;
    assign wr_en     = access && apb.pwrite;
    assign mtime_ofs = (ofs == CLINT_MTIME_LO_OFS) || (ofs == CLINT_MTIME_HI_OFS);

    always_comb begin
        ofs_hit = 1'b1;
        case (ofs)
            CLINT_MSIP_OFS:        apb.prdata = {{(DATA_W-1){1'b0}}, msip};
            CLINT_MTIMECMP_LO_OFS: apb.prdata = mtimecmp_q[DATA_W-1:0];
            CLINT_MTIMECMP_HI_OFS: apb.prdata = mtimecmp_q[2*DATA_W-1:DATA_W];
            CLINT_MTIME_LO_OFS:    apb.prdata = mtime_q[DATA_W-1:0];
            CLINT_MTIME_HI_OFS:    apb.prdata = mtime_q[2*DATA_W-1:DATA_W];
            default: begin
                apb.prdata = '0;
                ofs_hit    = 1'b0;
            end
        endcase
    end

    // mtime is read-only from the bus
    assign apb.pready  = 1'b1;
    assign apb.pslverr = access && (!ofs_hit || (apb.pwrite && mtime_ofs));

    // free-running system time
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mtime_q <= '0;
        end else begin
            mtime_q <= mtime_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mtimecmp_q <= '1;
            msip       <= 1'b0;
        end else if (wr_en) begin
            case (ofs)
                CLINT_MSIP_OFS: begin
                    if (apb.pstrb[0]) begin
                        msip <= apb.pwdata[0];
                    end
                end
                CLINT_MTIMECMP_LO_OFS:
                    mtimecmp_q[DATA_W-1:0] <=
                        apply_strb(mtimecmp_q[DATA_W-1:0], apb.pwdata, apb.pstrb);
                CLINT_MTIMECMP_HI_OFS:
                    mtimecmp_q[2*DATA_W-1:DATA_W] <=
                        apply_strb(mtimecmp_q[2*DATA_W-1:DATA_W], apb.pwdata, apb.pstrb);
                default: ;
            endcase
        end
    end

    // timer interrupt once the compare value is reached
    assign mtip = (mtime_q >= mtimecmp_q);

    a_mtime_monotonic: assert property (
        @(posedge clk) disable iff (!arst_n)
        (mtime_q != '1) |=> (mtime_q > $past(mtime_q))
    );

endmodule

`default_nettype wire

//--- cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_regs (
    input  logic                            clk,
    input  logic                            arst_n,
    apb_if.slave                            apb,
    output logic [soc_ctrl_pkg::DATA_W-1:0] core_bootvec,
    output logic [soc_ctrl_pkg::DATA_W-1:0] ddr_offset,
    output logic                            core_rstn
);
    import soc_ctrl_pkg::*;

    logic [SLV_SEL_LSB-1:0] ofs;
    logic                   access;
    logic                   wr_en;
    logic                   ofs_hit;

    assign ofs    = apb.paddr[SLV_SEL_LSB-1:0];
    assign access = apb.psel && apb.penable;
    assign wr_en  = access && apb.pwrite;

    // read mux, also flags unknown offsets
    always_comb begin
        ofs_hit = 1'b1;
        case (ofs)
            CFG_BOOTVEC_OFS:    apb.prdata = core_bootvec;
            CFG_DDR_OFFSET_OFS: apb.prdata = ddr_offset;
            CFG_CORE_RST_OFS:   apb.prdata = {{(DATA_W-1){1'b0}}, core_rstn};
            default: begin
                apb.prdata = '0;
                ofs_hit    = 1'b0;
            end
        endcase
    end

    assign apb.pready  = 1'b1;
    assign apb.pslverr = access && !ofs_hit;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            core_bootvec <= RESET_BOOTVEC;
            ddr_offset   <= RESET_DDR_OFFSET;
            core_rstn    <= 1'b0;
        end else if (wr_en) begin
            case (ofs)
                CFG_BOOTVEC_OFS:
                    core_bootvec <= apply_strb(core_bootvec, apb.pwdata, apb.pstrb);
                CFG_DDR_OFFSET_OFS:
                    ddr_offset <= apply_strb(ddr_offset, apb.pwdata, apb.pstrb);
                CFG_CORE_RST_OFS: begin
                    // only bit 0 is kept, core leaves reset when it is set
                    if (apb.pstrb[0]) begin
                        core_rstn <= apb.pwdata[0];
                    end
                end
                default: ;
            endcase
        end
    end

    a_rstn_by_write: assert property (
        @(posedge clk) disable iff (!arst_n)
        (core_rstn != $past(core_rstn)) |-> $past(wr_en && (ofs == CFG_CORE_RST_OFS))
    );

endmodule

`default_nettype wire

//--- apb_decode.sv
`timescale 1ns/1ps
`default_nettype none

module apb_decode (
    apb_if.slave  s,
    apb_if.master cfg,
    apb_if.master clint,
    apb_if.master irq
);
    import soc_ctrl_pkg::*;

    apb_slave_e sel;

    assign sel = apb_slave_e'(s.paddr[SLV_SEL_LSB +: 2]);

    // only the addressed block sees psel
    assign cfg.psel   = s.psel && (sel == SLV_CFG);
    assign clint.psel = s.psel && (sel == SLV_CLINT);
    assign irq.psel   = s.psel && (sel == SLV_IRQ);

    // everything else fans out unchanged
    assign cfg.penable   = s.penable;
    assign cfg.paddr     = s.paddr;
    assign cfg.pwrite    = s.pwrite;
    assign cfg.pstrb     = s.pstrb;
    assign cfg.pwdata    = s.pwdata;

    assign clint.penable = s.penable;
    assign clint.paddr   = s.paddr;
    assign clint.pwrite  = s.pwrite;
    assign clint.pstrb   = s.pstrb;
    assign clint.pwdata  = s.pwdata;

    assign irq.penable   = s.penable;
    assign irq.paddr     = s.paddr;
    assign irq.pwrite    = s.pwrite;
    assign irq.pstrb     = s.pstrb;
    assign irq.pwdata    = s.pwdata;

    // response mux, same cycle as the access
    always_comb begin
        case (sel)
            SLV_CFG: begin
                s.prdata  = cfg.prdata;
                s.pready  = cfg.pready;
                s.pslverr = cfg.pslverr;
            end
            SLV_CLINT: begin
                s.prdata  = clint.prdata;
                s.pready  = clint.pready;
                s.pslverr = clint.pslverr;
            end
            SLV_IRQ: begin
                s.prdata  = irq.prdata;
                s.pready  = irq.pready;
                s.pslverr = irq.pslverr;
            end
            default: begin
                // SLV_NONE, answered here with an error
                s.prdata  = '0;
                s.pready  = 1'b1;
                s.pslverr = s.psel && s.penable;
            end
        endcase
    end

    // an access cycle always follows a setup cycle on the upstream port
    a_setup_before_access: assert property (
        @(posedge s.clk) (s.psel && s.penable) |-> $past(s.psel && !s.penable)
    );

endmodule

`default_nettype wire

//--- apb_if.sv
`timescale 1ns/1ps
`default_nettype none

interface apb_if (
    input logic clk
);
    import soc_ctrl_pkg::*;

    logic              psel;
    logic              penable;
    logic [ADDR_W-1:0] paddr;
    logic              pwrite;
    logic [STRB_W-1:0] pstrb;
    logic [DATA_W-1:0] pwdata;
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;

    // clk is carried for protocol checks only
    modport master (
        input  clk,
        output psel, penable, paddr, pwrite, pstrb, pwdata,
        input  prdata, pready, pslverr
    );

    modport slave (
        input  clk,
        input  psel, penable, paddr, pwrite, pstrb, pwdata,
        output prdata, pready, pslverr
    );

endinterface

`default_nettype wire

//--- soc_ctrl_pkg.sv
`default_nettype none

package soc_ctrl_pkg;

    // apb geometry
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;

    // paddr[13:12] picks the target block
    localparam int SLV_SEL_LSB = 12;

    typedef enum logic [1:0] {
        SLV_CFG   = 2'd0,
        SLV_CLINT = 2'd1,
        SLV_IRQ   = 2'd2,
        SLV_NONE  = 2'd3
    } apb_slave_e;

    // configuration block
    localparam logic [SLV_SEL_LSB-1:0] CFG_BOOTVEC_OFS    = 12'h000;
    localparam logic [SLV_SEL_LSB-1:0] CFG_DDR_OFFSET_OFS = 12'h004;
    localparam logic [SLV_SEL_LSB-1:0] CFG_CORE_RST_OFS   = 12'h008;

    // timer block
    localparam logic [SLV_SEL_LSB-1:0] CLINT_MSIP_OFS        = 12'h000;
    localparam logic [SLV_SEL_LSB-1:0] CLINT_MTIMECMP_LO_OFS = 12'h008;
    localparam logic [SLV_SEL_LSB-1:0] CLINT_MTIMECMP_HI_OFS = 12'h00c;
    localparam logic [SLV_SEL_LSB-1:0] CLINT_MTIME_LO_OFS    = 12'h010;
    localparam logic [SLV_SEL_LSB-1:0] CLINT_MTIME_HI_OFS    = 12'h014;

    // interrupt gate
    localparam logic [SLV_SEL_LSB-1:0] IRQ_PENDING_OFS = 12'h000;
    localparam logic [SLV_SEL_LSB-1:0] IRQ_ENABLE_OFS  = 12'h004;

    // bit 0 reserved, bit 1 uart, bit 2 spi
    localparam int NUM_IRQ = 3;

    localparam logic [DATA_W-1:0] RESET_BOOTVEC    = 32'h0000_1000;
    localparam logic [DATA_W-1:0] RESET_DDR_OFFSET = 32'h8000_0000;

    // merge write data into a register, one byte lane per strobe bit
    function automatic logic [DATA_W-1:0] apply_strb(
        input logic [DATA_W-1:0] old_val,
        input logic [DATA_W-1:0] wdata,
        input logic [STRB_W-1:0] strb
    );
        logic [DATA_W-1:0] merged;
        merged = old_val;
        for (int i = 0; i < STRB_W; i++) begin
            if (strb[i]) begin
                merged[8*i +: 8] = wdata[8*i +: 8];
            end
        end
        return merged;
    endfunction

endpackage

`default_nettype wire
